/* Bender.yml */
package:
  name: ecc_98

sources:
  - source/ecc_98_pkg.sv
  - source/ecc_98_encoder.sv
  - source/ecc_98_check_stage.sv
  - source/ecc_98_syndrome_decoder.sv
  - source/ecc_98_correct_stage.sv
  - source/ecc_98_top.sv
  - target: test
    files:
      - testbench/tb_ecc_98_sva.sv
      - testbench/tb_ecc_98.sv

/* source/ecc_98_check_stage.sv */
module ecc_98_check_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  ecc_98_pkg::data_t     data_in,
    input  ecc_98_pkg::parity_t   parity_in,
    input  logic                  bypass,
    output logic                  s1_valid,
    output ecc_98_pkg::data_t     s1_data,
    output ecc_98_pkg::parity_t   s1_parity,
    output ecc_98_pkg::syndrome_u s1_syndrome,
    output logic                  s1_bypass
);

    import ecc_98_pkg::*;

    parity_t enc_parity;

    ecc_98_encoder u_encoder (
        .data   (data_in),
        .parity (enc_parity)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    // Word, encoding and syndrome captured together.
    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_data         <= data_in;
            s1_parity       <= enc_parity;
            s1_syndrome.raw <= enc_parity ^ parity_in;
            s1_bypass       <= bypass;
        end
    end

endmodule

/* source/ecc_98_correct_stage.sv */
module ecc_98_correct_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  s1_valid,
    input  ecc_98_pkg::data_t     s1_data,
    input  ecc_98_pkg::parity_t   s1_parity,
    input  ecc_98_pkg::syndrome_u s1_syndrome,
    input  logic                  s1_bypass,
    output logic                  out_valid,
    output ecc_98_pkg::data_t     data_out,
    output ecc_98_pkg::parity_t   parity_out,
    output ecc_98_pkg::data_t     mask,
    output logic                  sbit_err,
    output logic                  dbit_err
);

    import ecc_98_pkg::*;

    data_t dec_mask;
    logic  dec_single;
    logic  dec_multi;

    ecc_98_syndrome_decoder u_decoder (
        .syndrome (s1_syndrome),
        .mask     (dec_mask),
        .single   (dec_single),
        .multi    (dec_multi)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            sbit_err  <= 1'b0;
            dbit_err  <= 1'b0;
            mask      <= '0;
        end else begin
            out_valid <= s1_valid;
            if (s1_valid) begin
                mask     <= dec_mask;   // Reported even under bypass.
                sbit_err <= dec_single & ~s1_bypass;
                dbit_err <= dec_multi & ~s1_bypass;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            data_out   <= s1_bypass ? s1_data : (s1_data ^ dec_mask);
            parity_out <= s1_parity;
        end
    end

endmodule

/* source/ecc_98_encoder.sv */
module ecc_98_encoder (
    input  ecc_98_pkg::data_t   data,
    output ecc_98_pkg::parity_t parity
);

    import ecc_98_pkg::*;

    // Each data bit folds its column into the check word.
    always_comb begin
        parity = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            parity = parity ^ (data_column(i) & {PARITY_WIDTH{data[i]}});
        end
    end

endmodule

/* source/ecc_98_pkg.sv */
package ecc_98_pkg;

    localparam int DATA_WIDTH   = 98;
    localparam int PARITY_WIDTH = 8;
    localparam int POS_WIDTH    = 7;

    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [PARITY_WIDTH-1:0] parity_t;

    // Same word seen whole or as overall-parity bit plus Hamming position.
    typedef union packed {
        logic [PARITY_WIDTH-1:0] raw;
        struct packed {
            logic                 odd_sel;
            logic [POS_WIDTH-1:0] position;
        } fields;
    } syndrome_u;

    // Data index to Hamming position, stepping over the check-bit slots.
    function automatic logic [POS_WIDTH-1:0] data_position(input int unsigned index);
        int unsigned pos;
        pos = index + 1;
        for (int k = 0; k < POS_WIDTH; k++) begin
            if ((1 << k) <= pos) begin
                pos = pos + 1;
            end
        end
        return pos[POS_WIDTH-1:0];
    endfunction

    // Low bits are the position, bit 7 makes the weight odd.
    function automatic parity_t data_column(input int unsigned index);
        logic [POS_WIDTH-1:0] pos;
        pos = data_position(index);
        return {~^pos, pos};
    endfunction

    // Inverse of data_position. Index fits in a position-wide field.
    function automatic logic [POS_WIDTH-1:0] position_index(input logic [POS_WIDTH-1:0] pos);
        int unsigned skipped;
        int unsigned index;
        skipped = 0;
        for (int k = 0; k < POS_WIDTH; k++) begin
            if ((1 << k) <= int'(pos)) begin
                skipped = skipped + 1;
            end
        end
        index = int'(pos) - skipped - 1;
        return index[POS_WIDTH-1:0];
    endfunction

    // True only where a data bit sits.
    function automatic logic position_is_data(input logic [POS_WIDTH-1:0] pos);
        logic in_range;
        logic pow2;
        in_range = (pos >= POS_WIDTH'(3)) &&
                   (pos <= data_position(DATA_WIDTH - 1));
        pow2     = (pos & (pos - POS_WIDTH'(1))) == '0;
        return in_range && !pow2;
    endfunction

endpackage

/* source/ecc_98_syndrome_decoder.sv */
module ecc_98_syndrome_decoder (
    input  ecc_98_pkg::syndrome_u syndrome,
    output ecc_98_pkg::data_t     mask,
    output logic                  single,
    output logic                  multi
);

    import ecc_98_pkg::*;

    logic                 hit_data;
    parity_t              column;
    logic [POS_WIDTH-1:0] index;

    // Candidate data bit from the position field.
    always_comb begin
        index    = position_index(syndrome.fields.position);
        column   = data_column(index);
        hit_data = position_is_data(syndrome.fields.position) &&
                   (syndrome.fields.odd_sel == column[PARITY_WIDTH-1]);
    end

    always_comb begin
        mask   = '0;
        single = 1'b0;
        multi  = 1'b0;
        if (syndrome.raw != '0) begin
            if ($onehot(syndrome.raw)) begin
                single = 1'b1; // Check bit hit, data is fine.
            end else if (hit_data) begin
                single      = 1'b1;
                mask[index] = 1'b1;
            end else begin
                multi = 1'b1;  // Even weight or no matching column.
            end
        end
    end

endmodule

/* source/ecc_98_top.sv */
module ecc_98_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  ecc_98_pkg::data_t   data_in,
    input  ecc_98_pkg::parity_t parity_in,
    input  logic                bypass,
    output logic                out_valid,
    output ecc_98_pkg::data_t   data_out,
    output ecc_98_pkg::parity_t parity_out,
    output ecc_98_pkg::data_t   mask,
    output logic                sbit_err,
    output logic                dbit_err
);

    import ecc_98_pkg::*;

    // Stage 1 to stage 2.
    logic      s1_valid;
    data_t     s1_data;
    parity_t   s1_parity;
    syndrome_u s1_syndrome;
    logic      s1_bypass;

    ecc_98_check_stage u_check (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .data_in     (data_in),
        .parity_in   (parity_in),
        .bypass      (bypass),
        .s1_valid    (s1_valid),
        .s1_data     (s1_data),
        .s1_parity   (s1_parity),
        .s1_syndrome (s1_syndrome),
        .s1_bypass   (s1_bypass)
    );

    ecc_98_correct_stage u_correct (
        .clk         (clk),
        .rst_n       (rst_n),
        .s1_valid    (s1_valid),
        .s1_data     (s1_data),
        .s1_parity   (s1_parity),
        .s1_syndrome (s1_syndrome),
        .s1_bypass   (s1_bypass),
        .out_valid   (out_valid),
        .data_out    (data_out),
        .parity_out  (parity_out),
        .mask        (mask),
        .sbit_err    (sbit_err),
        .dbit_err    (dbit_err)
    );

endmodule

/* testbench/tb_ecc_98.sv */
module tb_ecc_98;

    import ecc_98_pkg::*;

    localparam int MAX_CYCLES  = 4000; // Roughly twice what the tests take.
    localparam int CODE_BITS   = DATA_WIDTH + PARITY_WIDTH;
    localparam int KIND_CLEAN  = 0;
    localparam int KIND_SINGLE = 1;
    localparam int KIND_DOUBLE = 2;
    localparam int KIND_BYPASS = 3;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    data_t   data_in;
    parity_t parity_in;
    logic    bypass;
    logic    out_valid;
    data_t   data_out;
    parity_t parity_out;
    data_t   mask;
    logic    sbit_err;
    logic    dbit_err;

    int seed;
    int cycle_count;

    // Current word and what should come out for it.
    data_t   w_data;
    parity_t w_parity;
    logic    w_bypass;
    data_t   x_data;
    parity_t x_parity;
    data_t   x_mask;
    logic    x_sbit;
    logic    x_dbit;

    ecc_98_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .data_in    (data_in),
        .parity_in  (parity_in),
        .bypass     (bypass),
        .out_valid  (out_valid),
        .data_out   (data_out),
        .parity_out (parity_out),
        .mask       (mask),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    always #20 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            abort_run($sformatf("Timeout: run did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: %s is 0x%h, expected 0x%h", $time, name, got, exp));
        end
    endtask

    task automatic check_parity(input string name, input parity_t got, input parity_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: %s is 0x%h, expected 0x%h", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    // Check bit k covers every data bit whose column has bit k set.
    function automatic parity_t expected_check_bits(input data_t d);
        parity_t p;
        parity_t col;
        logic    acc;
        for (int k = 0; k < PARITY_WIDTH; k++) begin
            acc = 1'b0;
            for (int i = 0; i < DATA_WIDTH; i++) begin
                col = data_column(i);
                if (col[k]) begin
                    acc = acc ^ d[i];
                end
            end
            p[k] = acc;
        end
        return p;
    endfunction

    function automatic data_t random_data();
        logic [127:0] w;
        w = {$random(seed), $random(seed), $random(seed), $random(seed)};
        return w[DATA_WIDTH-1:0];
    endfunction

    function automatic int unsigned random_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // Index below DATA_WIDTH is a data bit, above it a check bit.
    task automatic flip_bit(input int unsigned idx);
        if (idx < DATA_WIDTH) begin
            w_data[idx] = ~w_data[idx];
        end else begin
            w_parity[idx - DATA_WIDTH] = ~w_parity[idx - DATA_WIDTH];
        end
    endtask

    task automatic make_word(input int kind, input int unsigned ia, input int unsigned ib);
        data_t base;
        base     = random_data();
        w_data   = base;
        w_parity = expected_check_bits(base);
        w_bypass = (kind == KIND_BYPASS);
        if (kind != KIND_CLEAN) begin
            flip_bit(ia);
        end
        if (kind == KIND_DOUBLE) begin
            flip_bit(ib);
        end
        x_parity = expected_check_bits(w_data); // Recomputed from what was received.
        x_data   = (kind == KIND_DOUBLE || kind == KIND_BYPASS) ? w_data : base;
        x_mask   = '0;
        if ((kind == KIND_SINGLE || kind == KIND_BYPASS) && ia < DATA_WIDTH) begin
            x_mask[ia] = 1'b1;
        end
        x_sbit = (kind == KIND_SINGLE);
        x_dbit = (kind == KIND_DOUBLE);
    endtask

    task automatic check_outputs(input data_t e_d, input parity_t e_p, input data_t e_m,
                                 input logic e_s, input logic e_db);
        check_data("data_out", data_out, e_d);
        check_parity("parity_out", parity_out, e_p);
        check_data("mask", mask, e_m);
        check_bit("sbit_err", sbit_err, e_s);
        check_bit("dbit_err", dbit_err, e_db);
    endtask

    task automatic run_word();
        in_valid  = 1'b1;
        data_in   = w_data;
        parity_in = w_parity;
        bypass    = w_bypass;
        step();
        in_valid = 1'b0;
        if (out_valid) begin
            abort_run("out_valid rose one cycle after the strobe, one cycle early");
        end
        step();
        if (!out_valid) begin
            abort_run("out_valid did not rise two cycles after the strobe");
        end
        check_outputs(x_data, x_parity, x_mask, x_sbit, x_dbit);
    endtask

    task automatic test_clean_words();
        for (int n = 0; n < 300; n++) begin
            make_word(KIND_CLEAN, 0, 0);
            run_word();
        end
    endtask

    task automatic test_data_bit_errors();
        for (int r = 0; r < 4; r++) begin
            for (int i = 0; i < DATA_WIDTH; i++) begin
                make_word(KIND_SINGLE, i, 0);
                run_word();
            end
        end
    endtask

    task automatic test_check_bit_errors();
        for (int r = 0; r < 4; r++) begin
            for (int k = 0; k < PARITY_WIDTH; k++) begin
                make_word(KIND_SINGLE, DATA_WIDTH + k, 0);
                run_word();
            end
        end
    endtask

    task automatic test_double_errors();
        int unsigned ia;
        int unsigned ib;
        for (int n = 0; n < 200; n++) begin
            ia = random_below(CODE_BITS);
            do begin
                ib = random_below(CODE_BITS);
            end while (ib == ia);
            make_word(KIND_DOUBLE, ia, ib);
            run_word();
        end
    endtask

    task automatic test_bypass();
        for (int n = 0; n < 50; n++) begin
            make_word(KIND_BYPASS, random_below(DATA_WIDTH), 0);
            run_word();
        end
    endtask

    // Eight words with no gap, outputs must come back in order.
    task automatic test_back_to_back();
        data_t       b_in_data  [8];
        parity_t     b_in_par   [8];
        logic        b_in_byp   [8];
        data_t       b_exp_data [8];
        parity_t     b_exp_par  [8];
        data_t       b_exp_mask [8];
        logic        b_exp_sbit [8];
        logic        b_exp_dbit [8];
        int unsigned ia;
        int unsigned ib;
        for (int r = 0; r < 4; r++) begin
            for (int w = 0; w < 8; w++) begin
                ia = random_below(CODE_BITS);
                do begin
                    ib = random_below(CODE_BITS);
                end while (ib == ia);
                if (w % 4 == KIND_BYPASS) begin
                    ia = random_below(DATA_WIDTH);
                end
                make_word(w % 4, ia, ib);
                b_in_data[w]  = w_data;
                b_in_par[w]   = w_parity;
                b_in_byp[w]   = w_bypass;
                b_exp_data[w] = x_data;
                b_exp_par[w]  = x_parity;
                b_exp_mask[w] = x_mask;
                b_exp_sbit[w] = x_sbit;
                b_exp_dbit[w] = x_dbit;
            end
            for (int c = 0; c < 9; c++) begin
                if (c < 8) begin
                    in_valid  = 1'b1;
                    data_in   = b_in_data[c];
                    parity_in = b_in_par[c];
                    bypass    = b_in_byp[c];
                end else begin
                    in_valid = 1'b0;
                end
                step();
                if (c == 0) begin
                    if (out_valid) begin
                        abort_run("out_valid rose one cycle after the first strobe of a burst");
                    end
                end else if (!out_valid) begin
                    abort_run($sformatf("Missing out_valid pulse for burst word %0d", c - 1));
                end else begin
                    check_outputs(b_exp_data[c-1], b_exp_par[c-1], b_exp_mask[c-1],
                                  b_exp_sbit[c-1], b_exp_dbit[c-1]);
                end
            end
            step();
            if (out_valid) begin
                abort_run("Extra out_valid pulse after the end of a burst");
            end
        end
    endtask

    initial begin
        seed        = 32'hdad5fb3e;
        cycle_count = 0;
        clk         = 1'b0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        data_in     = '0;
        parity_in   = '0;
        bypass      = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        check_bit("out_valid", out_valid, 1'b0);   // Reset state.
        check_bit("sbit_err", sbit_err, 1'b0);
        check_bit("dbit_err", dbit_err, 1'b0);
        check_data("mask", mask, '0);
        rst_n = 1'b1;
        step();

        test_clean_words();
        test_data_bit_errors();
        test_check_bit_errors();
        test_double_errors();
        test_bypass();
        test_back_to_back();

        if (UUT.u_sva.fail_count != 0) begin
            abort_run("A bound assertion failed during the run");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

/* testbench/tb_ecc_98_sva.sv */
module tb_ecc_98_sva (
    input logic              clk,
    input logic              rst_n,
    input logic              in_valid,
    input logic              bypass,
    input logic              out_valid,
    input logic              sbit_err,
    input logic              dbit_err,
    input ecc_98_pkg::data_t mask
);

    int fail_count = 0;

    // Fixed two-cycle latency in both directions.
    a_latency_fwd : assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |=> ##1 out_valid)
        else begin
            $error("out_valid did not follow in_valid by two cycles");
            fail_count++;
        end

    a_latency_back : assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(in_valid, 2))
        else begin
            $error("out_valid without a strobe two cycles earlier");
            fail_count++;
        end

    a_flags_excl : assert property (@(posedge clk) disable iff (!rst_n)
        !(sbit_err && dbit_err))
        else begin
            $error("sbit_err and dbit_err both high");
            fail_count++;
        end

    a_mask_onehot : assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(mask))
        else begin
            $error("mask has more than one bit set");
            fail_count++;
        end

    a_bypass_flags : assert property (@(posedge clk) disable iff (!rst_n)
        $past(in_valid && bypass, 2) |-> (!sbit_err && !dbit_err))
        else begin
            $error("Error flag raised on a bypassed word");
            fail_count++;
        end

endmodule

bind ecc_98_top tb_ecc_98_sva u_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .bypass    (bypass),
    .out_valid (out_valid),
    .sbit_err  (sbit_err),
    .dbit_err  (dbit_err),
    .mask      (mask)
);

/* vlog.f */
source/ecc_98_pkg.sv
source/ecc_98_encoder.sv
source/ecc_98_check_stage.sv
source/ecc_98_syndrome_decoder.sv
source/ecc_98_correct_stage.sv
source/ecc_98_top.sv
testbench/tb_ecc_98_sva.sv
testbench/tb_ecc_98.sv
